// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing
TOP       ?= exu_tb
RTL_TOP   ?= exu_top
FILELIST  ?= exu.f
OBJ_DIR   ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "^TESTBENCH PASSED$$"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== design/exu_alu.sv ====
// rv64im alu
module exu_alu (
  input  exu_pkg::alu_op_e          i_alu_op,
  input  logic                      i_asrc_pc,
  input  exu_pkg::bsrc_e            i_bsrc,
  input  logic                      i_word_cut,
  input  logic [exu_pkg::XLEN-1:0]  i_pc,
  input  logic [exu_pkg::XLEN-1:0]  i_rs1,
  input  logic [exu_pkg::XLEN-1:0]  i_rs2,
  input  logic [exu_pkg::XLEN-1:0]  i_imm,
  output logic [exu_pkg::XLEN-1:0]  o_result,
  output logic                      o_zero,
  output logic                      o_less
);

  logic [exu_pkg::XLEN-1:0]         src1;
  logic [exu_pkg::XLEN-1:0]         src2;
  logic [exu_pkg::XLEN-1:0]         imm;
  logic [exu_pkg::XLEN-1:0]         src_a;
  logic [exu_pkg::XLEN-1:0]         src_b;
  logic [exu_pkg::XLEN-1:0]         add_result;
  logic [exu_pkg::XLEN-1:0]         sub_result;
  logic                             cout;
  logic                             overflow;
  logic                             signed_less;
  logic                             unsigned_less;
  logic [5:0]                       shamt;
  logic signed [exu_pkg::XLEN-1:0]  sra_src;
  logic [exu_pkg::XLEN-1:0]         sra_result;
  logic [2*exu_pkg::XLEN-1:0]       mul_uu;
  logic signed [2*exu_pkg::XLEN-1:0] mul_ss;
  logic signed [2*exu_pkg::XLEN-1:0] mul_su;
  logic                             div_zero;
  logic signed [exu_pkg::XLEN-1:0]  sdiv_a;
  logic signed [exu_pkg::XLEN-1:0]  sdiv_b;
  logic                             sdiv_ovf;
  logic signed [exu_pkg::XLEN-1:0]  sdiv_b_safe;
  logic [exu_pkg::XLEN-1:0]         udiv_b_safe;
  logic signed [exu_pkg::XLEN-1:0]  sdiv_q;
  logic signed [exu_pkg::XLEN-1:0]  srem_r;
  logic [exu_pkg::XLEN-1:0]         udiv_q;
  logic [exu_pkg::XLEN-1:0]         urem_r;
  logic [exu_pkg::XLEN-1:0]         raw_result;

  // word cut zero extends the low words
  assign src1 = i_word_cut ? {32'b0, i_rs1[31:0]} : i_rs1;
  assign src2 = i_word_cut ? {32'b0, i_rs2[31:0]} : i_rs2;
  assign imm  = i_word_cut ? {32'b0, i_imm[31:0]} : i_imm;

  // operand muxes
  assign src_a = i_asrc_pc ? i_pc : src1;
  always_comb begin
    case (i_bsrc)
      exu_pkg::BSRC_IMM:  src_b = imm;
      exu_pkg::BSRC_FOUR: src_b = 64'd4;
      default:            src_b = src2;
    endcase
  end

  // adder and subtractor, carry out high means no borrow
  assign add_result        = src_a + src_b;
  assign {cout, sub_result} = {1'b0, src_a} + {1'b0, ~src_b} + 65'd1;
  assign overflow          = (src_a[63] ^ src_b[63]) & (sub_result[63] ^ src_a[63]);
  assign signed_less       = sub_result[63] ^ overflow;
  assign unsigned_less     = ~cout;

  assign o_zero = ~(|sub_result);
  assign o_less = (i_alu_op == exu_pkg::ALU_SLTU) ? unsigned_less : signed_less;

  // word shifts take 5 bit amounts
  assign shamt      = i_word_cut ? {1'b0, src_b[4:0]} : src_b[5:0];
  assign sra_src    = i_word_cut ? {{32{src_a[31]}}, src_a[31:0]} : src_a;
  assign sra_result = sra_src >>> shamt;

  // one unsigned product also serves mul
  assign mul_uu = {64'b0, src_a} * {64'b0, src_b};
  assign mul_ss = $signed({{64{src_a[63]}}, src_a}) * $signed({{64{src_b[63]}}, src_b});
  assign mul_su = $signed({{64{src_a[63]}}, src_a}) * $signed({64'b0, src_b});

  // signed divide sees sign extended words
  assign div_zero = (src_b == 64'd0);
  assign sdiv_a   = i_word_cut ? {{32{src_a[31]}}, src_a[31:0]} : src_a;
  assign sdiv_b   = i_word_cut ? {{32{src_b[31]}}, src_b[31:0]} : src_b;
  assign sdiv_ovf = (sdiv_a == {1'b1, 63'b0}) && (&sdiv_b);

  // divide by one on overflow gives dividend and zero remainder
  assign sdiv_b_safe = (div_zero || sdiv_ovf) ? 64'sd1 : sdiv_b;
  assign udiv_b_safe = div_zero ? 64'd1 : src_b;

  assign sdiv_q = div_zero ? -64'sd1 : sdiv_a / sdiv_b_safe;
  assign srem_r = div_zero ? sdiv_a : sdiv_a % sdiv_b_safe;
  assign udiv_q = div_zero ? '1 : src_a / udiv_b_safe;
  assign urem_r = div_zero ? src_a : src_a % udiv_b_safe;

  always_comb begin
    case (i_alu_op)
      exu_pkg::ALU_COPY:   raw_result = i_imm;
      exu_pkg::ALU_SUB:    raw_result = sub_result;
      exu_pkg::ALU_SLT:    raw_result = {63'b0, signed_less};
      exu_pkg::ALU_SLTU:   raw_result = {63'b0, unsigned_less};
      exu_pkg::ALU_XOR:    raw_result = src_a ^ src_b;
      exu_pkg::ALU_AND:    raw_result = src_a & src_b;
      exu_pkg::ALU_OR:     raw_result = src_a | src_b;
      exu_pkg::ALU_SLL:    raw_result = src_a << shamt;
      exu_pkg::ALU_SRL:    raw_result = src_a >> shamt;
      exu_pkg::ALU_SRA:    raw_result = sra_result;
      exu_pkg::ALU_MUL:    raw_result = mul_uu[63:0];
      exu_pkg::ALU_MULH:   raw_result = mul_ss[127:64];
      exu_pkg::ALU_MULHSU: raw_result = mul_su[127:64];
      exu_pkg::ALU_MULHU:  raw_result = mul_uu[127:64];
      exu_pkg::ALU_DIV:    raw_result = sdiv_q;
      exu_pkg::ALU_DIVU:   raw_result = udiv_q;
      exu_pkg::ALU_REM:    raw_result = srem_r;
      exu_pkg::ALU_REMU:   raw_result = urem_r;
      default:             raw_result = add_result;
    endcase
  end

  // word results sign extend from bit 31
  assign o_result = i_word_cut ? {{32{raw_result[31]}}, raw_result[31:0]} : raw_result;

endmodule

// ==== design/exu_decode.sv ====
// instruction decoder
module exu_decode (
  input  logic [31:0]               i_inst,
  output exu_pkg::alu_op_e          o_alu_op,
  output logic                      o_asrc_pc,
  output exu_pkg::bsrc_e            o_bsrc,
  output logic                      o_word_cut,
  output logic [exu_pkg::XLEN-1:0]  o_imm,
  output logic [4:0]                o_rd,
  output logic                      o_rd_we,
  output exu_pkg::branch_kind_e     o_branch_kind,
  output logic                      o_illegal
);

  exu_pkg::opcode_e           opcode;
  logic [2:0]                 funct3;
  logic [6:0]                 funct7;
  logic [exu_pkg::XLEN-1:0]   imm_i;
  logic [exu_pkg::XLEN-1:0]   imm_u;
  logic [exu_pkg::XLEN-1:0]   imm_b;
  logic [exu_pkg::XLEN-1:0]   imm_j;
  logic                       shift64_ok;
  logic                       base32_ok;

  assign opcode = exu_pkg::opcode_e'(i_inst[6:0]);
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];
  assign o_rd   = i_inst[11:7];

  // sign extended immediates
  assign imm_i = {{52{i_inst[31]}}, i_inst[31:20]};
  assign imm_u = {{32{i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_b = {{52{i_inst[31]}}, i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
  assign imm_j = {{44{i_inst[31]}}, i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

  // srai takes bit 30, slli and srli need a clear top
  assign shift64_ok = (i_inst[31:26] == 6'b000000) ||
                      (i_inst[31:26] == 6'b010000 && funct3 == 3'b101);
  // word ops without M: add, sll, srl, plus sub and sra
  assign base32_ok  = (funct7 == 7'b0000000 && (funct3 == 3'b000 || funct3 == 3'b001 ||
                                                funct3 == 3'b101)) ||
                      (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));

  // base integer op, alt picks sub and sra
  function automatic exu_pkg::alu_op_e int_op(input logic [2:0] f3, input logic alt);
    exu_pkg::alu_op_e op;
    case (f3)
      3'b000:  op = alt ? exu_pkg::ALU_SUB : exu_pkg::ALU_ADD;
      3'b001:  op = exu_pkg::ALU_SLL;
      3'b010:  op = exu_pkg::ALU_SLT;
      3'b011:  op = exu_pkg::ALU_SLTU;
      3'b100:  op = exu_pkg::ALU_XOR;
      3'b101:  op = alt ? exu_pkg::ALU_SRA : exu_pkg::ALU_SRL;
      3'b110:  op = exu_pkg::ALU_OR;
      default: op = exu_pkg::ALU_AND;
    endcase
    return op;
  endfunction

  // M extension op
  function automatic exu_pkg::alu_op_e m_op(input logic [2:0] f3);
    exu_pkg::alu_op_e op;
    case (f3)
      3'b000:  op = exu_pkg::ALU_MUL;
      3'b001:  op = exu_pkg::ALU_MULH;
      3'b010:  op = exu_pkg::ALU_MULHSU;
      3'b011:  op = exu_pkg::ALU_MULHU;
      3'b100:  op = exu_pkg::ALU_DIV;
      3'b101:  op = exu_pkg::ALU_DIVU;
      3'b110:  op = exu_pkg::ALU_REM;
      default: op = exu_pkg::ALU_REMU;
    endcase
    return op;
  endfunction

  always_comb begin
    o_alu_op      = exu_pkg::ALU_ADD;
    o_asrc_pc     = 1'b0;
    o_bsrc        = exu_pkg::BSRC_RS2;
    o_word_cut    = 1'b0;
    o_imm         = imm_i;
    o_rd_we       = 1'b1;
    o_branch_kind = exu_pkg::BR_NONE;
    o_illegal     = 1'b0;
    case (opcode)
      exu_pkg::OPC_OP: begin
        o_alu_op  = funct7[0] ? m_op(funct3) : int_op(funct3, funct7[5]);
        o_illegal = !(funct7 == 7'b0000000 || funct7 == 7'b0000001 ||
                      (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101)));
      end
      exu_pkg::OPC_OP_IMM: begin
        o_bsrc    = exu_pkg::BSRC_IMM;
        o_alu_op  = int_op(funct3, funct3 == 3'b101 && i_inst[30]);
        o_illegal = (funct3 == 3'b001 || funct3 == 3'b101) && !shift64_ok;
      end
      exu_pkg::OPC_OP_32: begin
        o_word_cut = 1'b1;
        o_alu_op   = funct7[0] ? m_op(funct3) : int_op(funct3, funct7[5]);
        o_illegal  = !(base32_ok ||
                       (funct7 == 7'b0000001 && (funct3 == 3'b000 || funct3[2])));
      end
      exu_pkg::OPC_OP_IMM_32: begin
        o_word_cut = 1'b1;
        o_bsrc     = exu_pkg::BSRC_IMM;
        o_alu_op   = int_op(funct3, funct3 == 3'b101 && i_inst[30]);
        o_illegal  = !(funct3 == 3'b000 || base32_ok);
      end
      exu_pkg::OPC_LUI: begin
        o_alu_op = exu_pkg::ALU_COPY;
        o_imm    = imm_u;
      end
      exu_pkg::OPC_AUIPC: begin
        o_asrc_pc = 1'b1;
        o_bsrc    = exu_pkg::BSRC_IMM;
        o_imm     = imm_u;
      end
      exu_pkg::OPC_JAL: begin
        // link value pc + 4
        o_asrc_pc     = 1'b1;
        o_bsrc        = exu_pkg::BSRC_FOUR;
        o_imm         = imm_j;
        o_branch_kind = exu_pkg::BR_JAL;
      end
      exu_pkg::OPC_JALR: begin
        o_asrc_pc     = 1'b1;
        o_bsrc        = exu_pkg::BSRC_FOUR;
        o_branch_kind = exu_pkg::BR_JALR;
        o_illegal     = funct3 != 3'b000;
      end
      exu_pkg::OPC_BRANCH: begin
        o_imm   = imm_b;
        o_rd_we = 1'b0;
        case (funct3)
          3'b000: o_branch_kind = exu_pkg::BR_BEQ;
          3'b001: o_branch_kind = exu_pkg::BR_BNE;
          3'b100: o_branch_kind = exu_pkg::BR_BLT;
          3'b101: o_branch_kind = exu_pkg::BR_BGE;
          3'b110: o_branch_kind = exu_pkg::BR_BLTU;
          3'b111: o_branch_kind = exu_pkg::BR_BGEU;
          default: o_illegal = 1'b1;
        endcase
        // equality uses the zero flag of sub
        if (funct3[2]) begin
          o_alu_op = funct3[1] ? exu_pkg::ALU_SLTU : exu_pkg::ALU_SLT;
        end else begin
          o_alu_op = exu_pkg::ALU_SUB;
        end
      end
      default: o_illegal = 1'b1;
    endcase
    // illegal words neither write nor redirect
    if (o_illegal) begin
      o_branch_kind = exu_pkg::BR_NONE;
    end
    if (o_illegal || o_rd == 5'd0) begin
      o_rd_we = 1'b0;
    end
  end

endmodule

// ==== design/exu_pkg.sv ====
// execute stage definitions
package exu_pkg;

  // data path width, the word cut logic relies on 64
  localparam int XLEN = 64;

  // major opcodes handled by the stage
  typedef enum logic [6:0] {
    OPC_OP        = 7'b0110011,
    OPC_OP_IMM    = 7'b0010011,
    OPC_OP_32     = 7'b0111011,
    OPC_OP_IMM_32 = 7'b0011011,
    OPC_LUI       = 7'b0110111,
    OPC_AUIPC     = 7'b0010111,
    OPC_JAL       = 7'b1101111,
    OPC_JALR      = 7'b1100111,
    OPC_BRANCH    = 7'b1100011
  } opcode_e;

  // alu operation codes
  typedef enum logic [4:0] {
    ALU_ADD    = 5'b00000,
    ALU_SUB    = 5'b00001,
    ALU_SLT    = 5'b00010,
    ALU_SLTU   = 5'b00011,
    ALU_XOR    = 5'b00100,
    ALU_AND    = 5'b00101,
    ALU_OR     = 5'b00110,
    ALU_SLL    = 5'b00111,
    ALU_SRL    = 5'b01000,
    ALU_SRA    = 5'b01001,
    ALU_MUL    = 5'b01010,
    ALU_DIV    = 5'b01011,
    ALU_DIVU   = 5'b01100,
    ALU_REM    = 5'b01101,
    ALU_REMU   = 5'b01110,
    ALU_COPY   = 5'b01111,
    ALU_MULH   = 5'b11001,
    ALU_MULHSU = 5'b11010,
    ALU_MULHU  = 5'b11011
  } alu_op_e;

  // operand b source
  typedef enum logic [1:0] {
    BSRC_RS2  = 2'b00,
    BSRC_IMM  = 2'b01,
    BSRC_FOUR = 2'b10
  } bsrc_e;

  // branch and jump kinds
  typedef enum logic [3:0] {
    BR_NONE = 4'd0,
    BR_BEQ  = 4'd1,
    BR_BNE  = 4'd2,
    BR_BLT  = 4'd3,
    BR_BGE  = 4'd4,
    BR_BLTU = 4'd5,
    BR_BGEU = 4'd6,
    BR_JAL  = 4'd7,
    BR_JALR = 4'd8
  } branch_kind_e;

endpackage

// ==== design/exu_result.sv ====
// branch decision and output register
module exu_result (
  input  logic                      i_clock,
  input  logic                      i_reset,
  input  logic                      i_valid,
  input  logic [exu_pkg::XLEN-1:0]  i_pc,
  input  logic [exu_pkg::XLEN-1:0]  i_rs1,
  input  logic [exu_pkg::XLEN-1:0]  i_imm,
  input  logic [exu_pkg::XLEN-1:0]  i_alu_result,
  input  logic                      i_zero,
  input  logic                      i_less,
  input  logic [4:0]                i_rd,
  input  logic                      i_rd_we,
  input  exu_pkg::branch_kind_e     i_branch_kind,
  input  logic                      i_illegal,
  output logic                      o_valid,
  output logic [4:0]                o_rd,
  output logic                      o_rd_we,
  output logic [exu_pkg::XLEN-1:0]  o_rd_data,
  output logic                      o_branch_taken,
  output logic [exu_pkg::XLEN-1:0]  o_branch_target,
  output logic                      o_illegal
);

  logic                      taken;
  logic                      is_jalr;
  logic [exu_pkg::XLEN-1:0]  target_sum;

  always_comb begin
    case (i_branch_kind)
      exu_pkg::BR_BEQ:                  taken = i_zero;
      exu_pkg::BR_BNE:                  taken = ~i_zero;
      exu_pkg::BR_BLT, exu_pkg::BR_BLTU: taken = i_less;
      exu_pkg::BR_BGE, exu_pkg::BR_BGEU: taken = ~i_less;
      exu_pkg::BR_JAL, exu_pkg::BR_JALR: taken = 1'b1;
      default:                          taken = 1'b0;
    endcase
  end

  // shared target adder, jalr base is rs1
  assign is_jalr    = (i_branch_kind == exu_pkg::BR_JALR);
  assign target_sum = (is_jalr ? i_rs1 : i_pc) + i_imm;

  // control outputs
  always_ff @(posedge i_clock) begin
    if (i_reset) begin
      o_valid        <= 1'b0;
      o_rd_we        <= 1'b0;
      o_branch_taken <= 1'b0;
      o_illegal      <= 1'b0;
    end else begin
      o_valid        <= i_valid;
      o_rd_we        <= i_valid & i_rd_we;
      o_branch_taken <= i_valid & taken;
      o_illegal      <= i_valid & i_illegal;
    end
  end

  // payload holds until the next valid instruction
  always_ff @(posedge i_clock) begin
    if (i_valid) begin
      o_rd            <= i_rd;
      o_rd_data       <= i_alu_result;
      o_branch_target <= {target_sum[63:1], target_sum[0] & ~is_jalr};
    end
  end

endmodule

// ==== design/exu_top.sv ====
// integer execute stage
module exu_top (
  input  logic                      i_clock,
  input  logic                      i_reset,
  input  logic                      i_valid,
  input  logic [31:0]               i_inst,
  input  logic [exu_pkg::XLEN-1:0]  i_pc,
  input  logic [exu_pkg::XLEN-1:0]  i_rs1_data,
  input  logic [exu_pkg::XLEN-1:0]  i_rs2_data,
  output logic                      o_valid,
  output logic [4:0]                o_rd,
  output logic                      o_rd_we,
  output logic [exu_pkg::XLEN-1:0]  o_rd_data,
  output logic                      o_branch_taken,
  output logic [exu_pkg::XLEN-1:0]  o_branch_target,
  output logic                      o_illegal
);

  exu_pkg::alu_op_e           alu_op;
  logic                       asrc_pc;
  exu_pkg::bsrc_e             bsrc;
  logic                       word_cut;
  logic [exu_pkg::XLEN-1:0]   imm;
  logic [4:0]                 rd;
  logic                       rd_we;
  exu_pkg::branch_kind_e      branch_kind;
  logic                       illegal;
  logic [exu_pkg::XLEN-1:0]   alu_result;
  logic                       zero;
  logic                       less;

  exu_decode u_decode (
    .i_inst        (i_inst),
    .o_alu_op      (alu_op),
    .o_asrc_pc     (asrc_pc),
    .o_bsrc        (bsrc),
    .o_word_cut    (word_cut),
    .o_imm         (imm),
    .o_rd          (rd),
    .o_rd_we       (rd_we),
    .o_branch_kind (branch_kind),
    .o_illegal     (illegal)
  );

  exu_alu u_alu (
    .i_alu_op   (alu_op),
    .i_asrc_pc  (asrc_pc),
    .i_bsrc     (bsrc),
    .i_word_cut (word_cut),
    .i_pc       (i_pc),
    .i_rs1      (i_rs1_data),
    .i_rs2      (i_rs2_data),
    .i_imm      (imm),
    .o_result   (alu_result),
    .o_zero     (zero),
    .o_less     (less)
  );

  exu_result u_result (
    .i_clock         (i_clock),
    .i_reset         (i_reset),
    .i_valid         (i_valid),
    .i_pc            (i_pc),
    .i_rs1           (i_rs1_data),
    .i_imm           (imm),
    .i_alu_result    (alu_result),
    .i_zero          (zero),
    .i_less          (less),
    .i_rd            (rd),
    .i_rd_we         (rd_we),
    .i_branch_kind   (branch_kind),
    .i_illegal       (illegal),
    .o_valid         (o_valid),
    .o_rd            (o_rd),
    .o_rd_we         (o_rd_we),
    .o_rd_data       (o_rd_data),
    .o_branch_taken  (o_branch_taken),
    .o_branch_target (o_branch_target),
    .o_illegal       (o_illegal)
  );

endmodule

// ==== exu.f ====
+incdir+testbench
design/exu_pkg.sv
design/exu_decode.sv
design/exu_alu.sv
design/exu_result.sv
design/exu_top.sv
testbench/exu_tb.sv

// ==== testbench/exu_model.svh ====
// execute stage reference model
`ifndef EXU_MODEL_SVH
`define EXU_MODEL_SVH

typedef struct packed {
  logic [4:0]  rd;
  logic        rd_we;
  logic [63:0] rd_data;
  logic        taken;
  logic [63:0] target;
  logic        illegal;
} expect_t;

// rv64 base and M results, alt picks sub or sra
function automatic logic [63:0] calc64(input logic [2:0] f3, input logic alt, input logic m,
                                       input logic [63:0] a, input logic [63:0] b);
  logic [127:0]       pu;
  logic [63:0]        hs;
  logic [63:0]        r;
  logic               ovf;
  logic signed [63:0] sa;
  logic signed [63:0] sb;
  sa  = a;
  sb  = b;
  // signed high products from the unsigned one with sign corrections
  pu  = {64'b0, a} * {64'b0, b};
  hs  = pu[127:64] - (a[63] ? b : 64'd0);
  ovf = (a == {1'b1, 63'b0}) && (b == '1);
  if (m) begin
    case (f3)
      3'd0: r = pu[63:0];
      3'd1: r = hs - (b[63] ? a : 64'd0);
      3'd2: r = hs;
      3'd3: r = pu[127:64];
      3'd4, 3'd6: begin
        if (b == 64'd0) r = (f3 == 3'd4) ? '1 : a;
        else if (ovf) r = (f3 == 3'd4) ? a : 64'd0;
        else if (f3 == 3'd4) r = sa / sb;
        else r = sa % sb;
      end
      3'd5: r = (b == 64'd0) ? '1 : a / b;
      default: r = (b == 64'd0) ? a : a % b;
    endcase
  end else begin
    case (f3)
      3'd0: r = alt ? a - b : a + b;
      3'd1: r = a << b[5:0];
      3'd2: r = {63'b0, sa < sb};
      3'd3: r = {63'b0, a < b};
      3'd4: r = a ^ b;
      3'd5: r = alt ? 64'(sa >>> b[5:0]) : a >> b[5:0];
      3'd6: r = a | b;
      default: r = a & b;
    endcase
  end
  return r;
endfunction

// word forms as a 64 bit op on extended low words
function automatic logic [63:0] calc_word(input logic [2:0] f3, input logic alt, input logic m,
                                          input logic [63:0] a, input logic [63:0] b);
  logic        sx;
  logic [63:0] wa;
  logic [63:0] wb;
  logic [63:0] r;
  // signed divide and sraw look at the sign of the low word
  sx = m ? (f3 == 3'd4 || f3 == 3'd6) : (f3 == 3'd5 && alt);
  wa = {{32{sx & a[31]}}, a[31:0]};
  wb = {{32{sx & b[31]}}, b[31:0]};
  if (!m && (f3 == 3'd1 || f3 == 3'd5)) wb = {59'b0, b[4:0]};
  r = calc64(f3, alt, m, wa, wb);
  return {{32{r[31]}}, r[31:0]};
endfunction

// expected outputs for one instruction
function automatic expect_t model_exec(input logic [31:0] inst, input logic [63:0] pc,
                                       input logic [63:0] rs1, input logic [63:0] rs2);
  expect_t     e;
  logic [2:0]  f3;
  logic [6:0]  f7;
  logic [63:0] imm_i;
  logic [63:0] imm_u;
  logic        wr;
  f3    = inst[14:12];
  f7    = inst[31:25];
  imm_i = {{52{inst[31]}}, inst[31:20]};
  imm_u = {{32{inst[31]}}, inst[31:12], 12'b0};
  e     = '0;
  e.rd  = inst[11:7];
  wr    = 1'b1;
  case (inst[6:0])
    7'h33: begin
      e.illegal = !(f7 == 7'h00 || f7 == 7'h01 ||
                    (f7 == 7'h20 && f3 inside {3'd0, 3'd5}));
      e.rd_data = calc64(f3, f7[5], f7[0], rs1, rs2);
    end
    7'h13: begin
      e.illegal = (f3 == 3'd1 && inst[31:26] != 6'h00) ||
                  (f3 == 3'd5 && !(inst[31:26] inside {6'h00, 6'h10}));
      e.rd_data = calc64(f3, f3 == 3'd5 && inst[30], 1'b0, rs1, imm_i);
    end
    7'h3b: begin
      e.illegal = !((f7 == 7'h00 && f3 inside {3'd0, 3'd1, 3'd5}) ||
                    (f7 == 7'h20 && f3 inside {3'd0, 3'd5}) ||
                    (f7 == 7'h01 && f3 inside {3'd0, 3'd4, 3'd5, 3'd6, 3'd7}));
      e.rd_data = calc_word(f3, f7[5], f7[0], rs1, rs2);
    end
    7'h1b: begin
      e.illegal = !(f3 == 3'd0 || (f7 == 7'h00 && f3 inside {3'd1, 3'd5}) ||
                    (f7 == 7'h20 && f3 == 3'd5));
      e.rd_data = calc_word(f3, f3 == 3'd5 && inst[30], 1'b0, rs1, imm_i);
    end
    7'h37: e.rd_data = imm_u;
    7'h17: e.rd_data = pc + imm_u;
    7'h6f: begin
      e.rd_data = pc + 64'd4;
      e.taken   = 1'b1;
      e.target  = pc + {{44{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    end
    7'h67: begin
      e.illegal = (f3 != 3'd0);
      e.rd_data = pc + 64'd4;
      e.taken   = 1'b1;
      e.target  = (rs1 + imm_i) & ~64'd1;
    end
    7'h63: begin
      wr        = 1'b0;
      e.illegal = f3 inside {3'd2, 3'd3};
      e.target  = pc + {{52{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
      case (f3)
        3'd0: e.taken = (rs1 == rs2);
        3'd1: e.taken = (rs1 != rs2);
        3'd4: e.taken = ($signed(rs1) < $signed(rs2));
        3'd5: e.taken = ($signed(rs1) >= $signed(rs2));
        3'd6: e.taken = (rs1 < rs2);
        default: e.taken = (rs1 >= rs2);
      endcase
    end
    default: e.illegal = 1'b1;
  endcase
  if (e.illegal) begin
    e.taken = 1'b0;
    wr      = 1'b0;
  end
  e.rd_we = wr && (e.rd != 5'd0);
  return e;
endfunction

`endif

// ==== testbench/exu_tb.sv ====
// execute stage testbench
module exu_tb;
  timeunit 1ns;
  timeprecision 1ps;

  `include "exu_model.svh"

  localparam int NUM_INSTS   = 4000;
  localparam int DRAIN_LIMIT = 20;

  logic        i_clock;
  logic        i_reset;
  logic        i_valid;
  logic [31:0] i_inst;
  logic [63:0] i_pc;
  logic [63:0] i_rs1_data;
  logic [63:0] i_rs2_data;
  logic        o_valid;
  logic [4:0]  o_rd;
  logic        o_rd_we;
  logic [63:0] o_rd_data;
  logic        o_branch_taken;
  logic [63:0] o_branch_target;
  logic        o_illegal;

  expect_t     exp_q[$];
  string       name_q[$];
  logic        captured_valid;
  int          error_count = 0;
  int          check_count = 0;

  exu_top dut0 (
    .i_clock         (i_clock),
    .i_reset         (i_reset),
    .i_valid         (i_valid),
    .i_inst          (i_inst),
    .i_pc            (i_pc),
    .i_rs1_data      (i_rs1_data),
    .i_rs2_data      (i_rs2_data),
    .o_valid         (o_valid),
    .o_rd            (o_rd),
    .o_rd_we         (o_rd_we),
    .o_rd_data       (o_rd_data),
    .o_branch_taken  (o_branch_taken),
    .o_branch_target (o_branch_target),
    .o_illegal       (o_illegal)
  );

  always #2 i_clock = ~i_clock;

  // random instruction of one class, fields not set stay random
  task automatic make_inst(output logic [31:0] inst, output string name);
    int         cls;
    logic [2:0] f3;
    logic [6:0] f7;
    logic [6:0] opc;
    cls  = $urandom_range(0, 11);
    inst = $urandom;
    f3   = 3'($urandom);
    f7   = inst[31:25];
    case (cls)
      0: begin
        name = "op";
        opc  = 7'h33;
        f7   = ((f3 == 3'd0 || f3 == 3'd5) && $urandom_range(0, 1) == 1) ? 7'h20 : 7'h00;
      end
      1: begin
        name = "op_m";
        opc  = 7'h33;
        f7   = 7'h01;
      end
      2: begin
        name = "op_imm";
        opc  = 7'h13;
        if (f3 == 3'd1 || f3 == 3'd5) f7[6:1] = (f3 == 3'd5 && f7[5]) ? 6'h10 : 6'h00;
      end
      3, 5: begin
        name = (cls == 3) ? "op_32" : "op_imm_32";
        opc  = (cls == 3) ? 7'h3b : 7'h1b;
        f3   = 3'($urandom_range(0, 2));
        if (f3 == 3'd2) f3 = 3'd5;
        if (cls == 3 || f3 != 3'd0) f7 = (f3 != 3'd1 && f7[5]) ? 7'h20 : 7'h00;
      end
      4: begin
        name = "op_32_m";
        opc  = 7'h3b;
        f3   = ($urandom_range(0, 4) == 0) ? 3'd0 : 3'($urandom_range(4, 7));
        f7   = 7'h01;
      end
      6: begin
        name = "lui";
        opc  = 7'h37;
        f3   = inst[14:12];
      end
      7: begin
        name = "auipc";
        opc  = 7'h17;
        f3   = inst[14:12];
      end
      8: begin
        name = "jal";
        opc  = 7'h6f;
        f3   = inst[14:12];
      end
      9: begin
        name = "jalr";
        opc  = 7'h67;
        f3   = 3'd0;
      end
      10: begin
        name = "branch";
        opc  = 7'h63;
        f3   = f3[1] ? 3'($urandom_range(4, 7)) : {2'b00, f3[0]};
      end
      default: begin
        // mostly unknown opcodes
        name = "random_word";
        opc  = inst[6:0];
        f3   = inst[14:12];
      end
    endcase
    inst[31:25] = f7;
    inst[14:12] = f3;
    inst[6:0]   = opc;
    if ($urandom_range(0, 9) == 0) inst[11:7] = 5'd0;
  endtask

  // operands with division corner cases and equal values mixed in
  task automatic make_operands(output logic [63:0] rs1, output logic [63:0] rs2);
    rs1 = {$urandom, $urandom};
    rs2 = {$urandom, $urandom};
    case ($urandom_range(0, 9))
      0: rs2 = 64'd0;
      1: rs2 = {32'($urandom), 32'd0};
      2: begin
        rs1 = {1'b1, 63'd0};
        rs2 = '1;
      end
      3: begin
        rs1 = {32'($urandom), 32'h8000_0000};
        rs2 = {32'($urandom), 32'hffff_ffff};
      end
      4: rs2 = rs1;
      default: rs2 = rs2;
    endcase
  endtask

  task automatic check_value(input string test, input string field,
                             input logic [63:0] exp, input logic [63:0] act);
    check_count++;
    assert (act === exp) else begin
      $display("CHECK FAILED %s %s expected %h actual %h", test, field, exp, act);
      error_count++;
    end
  endtask

  task automatic compare_outputs(input string test, input expect_t e);
    check_value(test, "illegal", 64'(e.illegal), 64'(o_illegal));
    check_value(test, "rd", 64'(e.rd), 64'(o_rd));
    check_value(test, "rd_we", 64'(e.rd_we), 64'(o_rd_we));
    check_value(test, "branch_taken", 64'(e.taken), 64'(o_branch_taken));
    if (e.rd_we) check_value(test, "rd_data", e.rd_data, o_rd_data);
    if (e.taken) check_value(test, "branch_target", e.target, o_branch_target);
  endtask

  // strobe seen by the dut at each edge
  always @(posedge i_clock) begin
    if (i_reset) captured_valid <= 1'b0;
    else captured_valid <= i_valid;
  end

  // outputs are sampled mid cycle
  always @(negedge i_clock) begin
    if (!i_reset) begin
      assert (o_valid === captured_valid) else begin
        $display("CHECK FAILED latency o_valid expected %b actual %b", captured_valid, o_valid);
        error_count++;
      end
      if (o_valid === 1'b1) begin
        if (exp_q.size() == 0) begin
          $display("o_valid went high with no instruction pending");
          error_count++;
        end else begin
          compare_outputs(name_q.pop_front(), exp_q.pop_front());
        end
      end else begin
        assert (o_rd_we === 1'b0 && o_branch_taken === 1'b0 && o_illegal === 1'b0) else begin
          $display("write enable, taken or illegal is high while o_valid is low");
          error_count++;
        end
      end
    end
  end

  initial begin
    logic [31:0] inst;
    logic [63:0] pc;
    logic [63:0] rs1;
    logic [63:0] rs2;
    logic        valid;
    string       name;
    int          wait_cycles;
    i_clock    = 1'b0;
    i_reset    = 1'b1;
    i_valid    = 1'b0;
    i_inst     = 32'd0;
    i_pc       = 64'd0;
    i_rs1_data = 64'd0;
    i_rs2_data = 64'd0;
    void'($urandom(32'hd3bb5a61));
    repeat (4) @(posedge i_clock);
    i_reset <= 1'b0;
    for (int n = 0; n < NUM_INSTS; n++) begin
      @(posedge i_clock);
      make_inst(inst, name);
      make_operands(rs1, rs2);
      pc    = {$urandom, $urandom} & ~64'd3;
      valid = ($urandom_range(0, 3) != 0);
      i_valid    <= valid;
      i_inst     <= inst;
      i_pc       <= pc;
      i_rs1_data <= rs1;
      i_rs2_data <= rs2;
      if (valid) begin
        exp_q.push_back(model_exec(inst, pc, rs1, rs2));
        name_q.push_back(name);
      end
    end
    @(posedge i_clock);
    i_valid <= 1'b0;
    // let the last results drain
    wait_cycles = 0;
    while (exp_q.size() != 0 && wait_cycles < DRAIN_LIMIT) begin
      @(posedge i_clock);
      wait_cycles++;
    end
    if (exp_q.size() != 0) begin
      $display("timeout: %0d results never came out of the DUT", exp_q.size());
      error_count++;
    end
    $display("checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule
